// ==== logic/armCorePkg.sv ====
// Datapath word, register index and flag types, PC step and reset constants
package armCorePkg;

   // 32-bit data and address word
   typedef logic [31:0] wordT;

   // Register index, R0 to R15
   typedef logic [3:0] regAdrT;

   // Status flags packed as {N, Z, C, V}
   typedef logic [3:0] flagsT;

   localparam wordT WORD_BYTES = 32'd4;     // PC step per instruction

   // R15 reads two instructions ahead of the executing one
   localparam wordT PC_READ_AHEAD = 32'd8;

   localparam regAdrT PC_REG = 4'd15;       // Index of R15

   localparam wordT RESET_PC = 32'h0000_0000;

endpackage

// ==== logic/armIsaPkg.sv ====
// Instruction field positions plus opcode, condition, ALU operation and immediate kind encodings
package armIsaPkg;

   typedef logic [1:0] opT;       // Major opcode, instr[27:26]
   typedef logic [3:0] condT;
   typedef logic [1:0] aluOpT;
   typedef logic [3:0] dpCmdT;    // Data processing command field
   typedef logic [1:0] immKindT;

   localparam opT OP_DP     = 2'b00;
   localparam opT OP_MEM    = 2'b01;
   localparam opT OP_BRANCH = 2'b10;

   // Condition codes in architectural order
   localparam condT COND_EQ = 4'b0000;
   localparam condT COND_NE = 4'b0001;
   localparam condT COND_CS = 4'b0010;
   localparam condT COND_CC = 4'b0011;
   localparam condT COND_MI = 4'b0100;
   localparam condT COND_PL = 4'b0101;
   localparam condT COND_VS = 4'b0110;
   localparam condT COND_VC = 4'b0111;
   localparam condT COND_HI = 4'b1000;
   localparam condT COND_LS = 4'b1001;
   localparam condT COND_GE = 4'b1010;
   localparam condT COND_LT = 4'b1011;
   localparam condT COND_GT = 4'b1100;
   localparam condT COND_LE = 4'b1101;
   localparam condT COND_AL = 4'b1110;

   localparam aluOpT ALU_ADD = 2'b00;
   localparam aluOpT ALU_SUB = 2'b01;   // Low bit selects inverted B plus carry in
   localparam aluOpT ALU_AND = 2'b10;
   localparam aluOpT ALU_ORR = 2'b11;

   localparam dpCmdT CMD_AND = 4'b0000;
   localparam dpCmdT CMD_SUB = 4'b0010;
   localparam dpCmdT CMD_ADD = 4'b0100;
   localparam dpCmdT CMD_ORR = 4'b1100;

   localparam immKindT IMM_DP8      = 2'b00;
   localparam immKindT IMM_MEM12    = 2'b01;
   localparam immKindT IMM_BRANCH24 = 2'b10;

   // Field positions within the instruction word
   localparam int COND_MSB  = 31;
   localparam int COND_LSB  = 28;
   localparam int OP_MSB    = 27;
   localparam int OP_LSB    = 26;
   localparam int I_BIT     = 25;
   localparam int CMD_MSB   = 24;
   localparam int CMD_LSB   = 21;
   localparam int S_BIT     = 20;
   localparam int L_BIT     = 20;   // Same position as S, meaning depends on opcode
   localparam int RN_MSB    = 19;
   localparam int RN_LSB    = 16;
   localparam int RD_MSB    = 15;
   localparam int RD_LSB    = 12;
   localparam int RM_MSB    = 3;
   localparam int RM_LSB    = 0;
   localparam int IMM8_MSB  = 7;
   localparam int IMM12_MSB = 11;
   localparam int IMM24_MSB = 23;

endpackage

// ==== logic/armControl.sv ====
// Control module: main and ALU decode, flag registers, condition check and write gating
`timescale 1ns/1ps

module armControl (
   input  logic                clk,
   input  logic                reset,
   input  armCorePkg::wordT    instr,
   input  armCorePkg::flagsT   aluFlags,
   output armIsaPkg::immKindT  immKind,
   output logic                aluSrcImm,
   output armIsaPkg::aluOpT    aluOp,
   output logic                memToReg,
   output logic                regSrcPc,
   output logic                regSrcStore,
   output logic                regWrite,
   output logic                memWrite,
   output logic                pcSrcResult
);
   armIsaPkg::opT      op;
   armIsaPkg::condT    cond;
   armIsaPkg::dpCmdT   cmd;
   armCorePkg::regAdrT rd;
   armCorePkg::flagsT  flags;
   logic [1:0]         nzFlags;
   logic [1:0]         cvFlags;
   logic sBit, lBit;
   logic isDp, isBranch, regW, memW, pcReq;
   logic flagWNz, flagWCv;
   logic neg, zero, carry, overflow, ge, condEx;

   assign op   = instr[armIsaPkg::OP_MSB:armIsaPkg::OP_LSB];
   assign cond = instr[armIsaPkg::COND_MSB:armIsaPkg::COND_LSB];
   assign cmd  = instr[armIsaPkg::CMD_MSB:armIsaPkg::CMD_LSB];
   assign rd   = instr[armIsaPkg::RD_MSB:armIsaPkg::RD_LSB];
   assign sBit = instr[armIsaPkg::S_BIT];
   assign lBit = instr[armIsaPkg::L_BIT];

   // Main decode, raw controls before the condition check
   always_comb begin
      immKind     = armIsaPkg::IMM_DP8;
      aluSrcImm   = 1'b0;
      memToReg    = 1'b0;
      regSrcPc    = 1'b0;
      regSrcStore = 1'b0;
      regW        = 1'b0;
      memW        = 1'b0;
      isDp        = 1'b0;
      isBranch    = 1'b0;
      case (op)
         armIsaPkg::OP_DP: begin
            aluSrcImm = instr[armIsaPkg::I_BIT];
            regW      = 1'b1;
            isDp      = 1'b1;
         end
         armIsaPkg::OP_MEM: begin
            immKind     = armIsaPkg::IMM_MEM12;
            aluSrcImm   = 1'b1;
            memToReg    = lBit;
            regW        = lBit;     // LDR
            memW        = ~lBit;    // STR
            regSrcStore = ~lBit;    // Store data comes from Rd
         end
         armIsaPkg::OP_BRANCH: begin
            immKind   = armIsaPkg::IMM_BRANCH24;
            aluSrcImm = 1'b1;
            regSrcPc  = 1'b1;
            isBranch  = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // ALU decode; loads, stores and branches add
   always_comb begin
      aluOp = armIsaPkg::ALU_ADD;
      if (isDp) begin
         case (cmd)
            armIsaPkg::CMD_ADD: aluOp = armIsaPkg::ALU_ADD;
            armIsaPkg::CMD_SUB: aluOp = armIsaPkg::ALU_SUB;
            armIsaPkg::CMD_AND: aluOp = armIsaPkg::ALU_AND;
            armIsaPkg::CMD_ORR: aluOp = armIsaPkg::ALU_ORR;
            default:            aluOp = armIsaPkg::ALU_ADD;
         endcase
      end
   end

   assign pcReq = isBranch | (regW & (rd == armCorePkg::PC_REG));

   // C and V only follow arithmetic
   assign flagWNz = isDp & sBit & condEx;
   assign flagWCv = flagWNz &
                    ((aluOp == armIsaPkg::ALU_ADD) || (aluOp == armIsaPkg::ALU_SUB));

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         nzFlags <= 2'b00;
      end else if (flagWNz) begin
         nzFlags <= aluFlags[3:2];
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cvFlags <= 2'b00;
      end else if (flagWCv) begin
         cvFlags <= aluFlags[1:0];
      end
   end

   assign flags = {nzFlags, cvFlags};
   assign {neg, zero, carry, overflow} = flags;
   assign ge = (neg == overflow);

   always_comb begin
      case (cond)
         armIsaPkg::COND_EQ: condEx = zero;
         armIsaPkg::COND_NE: condEx = ~zero;
         armIsaPkg::COND_CS: condEx = carry;
         armIsaPkg::COND_CC: condEx = ~carry;
         armIsaPkg::COND_MI: condEx = neg;
         armIsaPkg::COND_PL: condEx = ~neg;
         armIsaPkg::COND_VS: condEx = overflow;
         armIsaPkg::COND_VC: condEx = ~overflow;
         armIsaPkg::COND_HI: condEx = carry & ~zero;
         armIsaPkg::COND_LS: condEx = ~carry | zero;
         armIsaPkg::COND_GE: condEx = ge;
         armIsaPkg::COND_LT: condEx = ~ge;
         armIsaPkg::COND_GT: condEx = ~zero & ge;
         armIsaPkg::COND_LE: condEx = zero | ~ge;
         armIsaPkg::COND_AL: condEx = 1'b1;
         default:            condEx = 1'b0;   // 1111 never executes
      endcase
   end

   assign regWrite    = regW & condEx & ~reset;
   assign memWrite    = memW & condEx & ~reset;
   assign pcSrcResult = pcReq & condEx;

endmodule

// ==== logic/pcUnit.sv ====
// Program counter register, PC+4 and PC+8 adders and next-PC select
`timescale 1ns/1ps

module pcUnit (
   input  logic             clk,
   input  logic             reset,
   input  logic             pcSrcResult,
   input  armCorePkg::wordT result,
   output armCorePkg::wordT pc,
   output armCorePkg::wordT pcPlus8
);
   armCorePkg::wordT pcPlus4;
   armCorePkg::wordT pcNext;

   assign pcPlus4 = pc + armCorePkg::WORD_BYTES;
   assign pcPlus8 = pc + armCorePkg::PC_READ_AHEAD;   // R15 as seen by the ISA

   // Branch target or R15 write redirects
   assign pcNext = pcSrcResult ? result : pcPlus4;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= armCorePkg::RESET_PC;
      end else begin
         pc <= pcNext;
      end
   end

endmodule

// ==== logic/regFile.sv ====
// Register file with R0 to R14, R15 read as PC+8, two read ports and one write port
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             regWrite,
   input  armCorePkg::wordT instr,
   input  logic             regSrcPc,
   input  logic             regSrcStore,
   input  armCorePkg::wordT pcPlus8,
   input  armCorePkg::wordT result,
   output armCorePkg::wordT srcA,
   output armCorePkg::wordT rdB
);
   armCorePkg::wordT   regs [0:armCorePkg::PC_REG-1];
   armCorePkg::regAdrT readAdrA;
   armCorePkg::regAdrT readAdrB;
   armCorePkg::regAdrT writeAdr;

   // Branches read R15 as the base
   assign readAdrA = regSrcPc ? armCorePkg::PC_REG
                              : instr[armIsaPkg::RN_MSB:armIsaPkg::RN_LSB];
   // STR reads its data from Rd
   assign readAdrB = regSrcStore ? instr[armIsaPkg::RD_MSB:armIsaPkg::RD_LSB]
                                 : instr[armIsaPkg::RM_MSB:armIsaPkg::RM_LSB];
   assign writeAdr = instr[armIsaPkg::RD_MSB:armIsaPkg::RD_LSB];

   // R15 writes go to the PC instead
   always_ff @(posedge clk) begin
      if (regWrite && (writeAdr != armCorePkg::PC_REG)) begin
         regs[writeAdr] <= result;
      end
   end

   assign srcA = (readAdrA == armCorePkg::PC_REG) ? pcPlus8 : regs[readAdrA];
   assign rdB  = (readAdrB == armCorePkg::PC_REG) ? pcPlus8 : regs[readAdrB];

endmodule

// ==== logic/executeUnit.sv ====
// Immediate extension, operand B select, ALU with flags and result select
`timescale 1ns/1ps

module executeUnit (
   input  armCorePkg::wordT   instr,
   input  armIsaPkg::immKindT immKind,
   input  logic               aluSrcImm,
   input  armIsaPkg::aluOpT   aluOp,
   input  logic               memToReg,
   input  armCorePkg::wordT   srcA,
   input  armCorePkg::wordT   rdB,
   input  armCorePkg::wordT   readData,
   output armCorePkg::wordT   aluResult,
   output armCorePkg::flagsT  aluFlags,
   output armCorePkg::wordT   result
);
   armCorePkg::wordT extImm;
   armCorePkg::wordT srcB;
   armCorePkg::wordT bInv;
   logic [32:0]      sum;
   logic             isSub;
   logic             isArith;
   logic             neg, zero, carry, overflow;

   always_comb begin
      case (immKind)
         armIsaPkg::IMM_DP8:
            extImm = {24'b0, instr[armIsaPkg::IMM8_MSB:0]};
         armIsaPkg::IMM_MEM12:
            extImm = {20'b0, instr[armIsaPkg::IMM12_MSB:0]};
         armIsaPkg::IMM_BRANCH24:   // Word offset, sign extended
            extImm = {{6{instr[armIsaPkg::IMM24_MSB]}}, instr[armIsaPkg::IMM24_MSB:0], 2'b00};
         default:
            extImm = '0;
      endcase
   end

   assign srcB = aluSrcImm ? extImm : rdB;

   // Subtract as A + ~B + 1
   assign isSub   = (aluOp == armIsaPkg::ALU_SUB);
   assign isArith = (aluOp == armIsaPkg::ALU_ADD) || isSub;
   assign bInv    = isSub ? ~srcB : srcB;
   assign sum     = {1'b0, srcA} + {1'b0, bInv} + {32'b0, isSub};

   always_comb begin
      case (aluOp)
         armIsaPkg::ALU_AND: aluResult = srcA & srcB;
         armIsaPkg::ALU_ORR: aluResult = srcA | srcB;
         default:            aluResult = sum[31:0];   // ADD and SUB
      endcase
   end

   assign neg   = aluResult[31];
   assign zero  = (aluResult == '0);
   assign carry = isArith & sum[32];   // Carry out, so C set means no borrow
   // Overflow when operands agree in sign and the sum does not
   assign overflow = isArith & ~(srcA[31] ^ srcB[31] ^ isSub) & (srcA[31] ^ sum[31]);
   assign aluFlags = {neg, zero, carry, overflow};

   assign result = memToReg ? readData : aluResult;

endmodule

// ==== logic/armCore.sv ====
// Single-cycle core top level connecting control, PC unit, register file and execute unit
`timescale 1ns/1ps

module armCore (
   input  logic             clk,
   input  logic             reset,
   input  armCorePkg::wordT instr,
   input  armCorePkg::wordT readData,
   output armCorePkg::wordT instrAdr,
   output logic             memWrite,
   output armCorePkg::wordT dataAdr,
   output armCorePkg::wordT writeData
);
   armIsaPkg::immKindT immKind;
   armIsaPkg::aluOpT   aluOp;
   armCorePkg::flagsT  aluFlags;
   armCorePkg::wordT   pcPlus8;
   armCorePkg::wordT   srcA;
   armCorePkg::wordT   result;
   logic aluSrcImm, memToReg, regSrcPc, regSrcStore, regWrite, pcSrcResult;

   armControl control (
      .clk         (clk),
      .reset       (reset),
      .instr       (instr),
      .aluFlags    (aluFlags),
      .immKind     (immKind),
      .aluSrcImm   (aluSrcImm),
      .aluOp       (aluOp),
      .memToReg    (memToReg),
      .regSrcPc    (regSrcPc),
      .regSrcStore (regSrcStore),
      .regWrite    (regWrite),
      .memWrite    (memWrite),
      .pcSrcResult (pcSrcResult)
   );

   pcUnit pcGen (
      .clk         (clk),
      .reset       (reset),
      .pcSrcResult (pcSrcResult),
      .result      (result),
      .pc          (instrAdr),
      .pcPlus8     (pcPlus8)
   );

   // Second read port doubles as store data
   regFile regs (
      .clk         (clk),
      .regWrite    (regWrite),
      .instr       (instr),
      .regSrcPc    (regSrcPc),
      .regSrcStore (regSrcStore),
      .pcPlus8     (pcPlus8),
      .result      (result),
      .srcA        (srcA),
      .rdB         (writeData)
   );

   executeUnit execute (
      .instr     (instr),
      .immKind   (immKind),
      .aluSrcImm (aluSrcImm),
      .aluOp     (aluOp),
      .memToReg  (memToReg),
      .srcA      (srcA),
      .rdB       (writeData),
      .readData  (readData),
      .aluResult (dataAdr),   // ALU result addresses data memory
      .aluFlags  (aluFlags),
      .result    (result)
   );

endmodule

// ==== verif/armCore_checker.sv ====
// Concurrent assertions on reset store gating, fetch alignment and known outputs of armCore
`timescale 1ns/1ps

module armCore_checker (
   input logic             clk,
   input logic             reset,
   input logic             memWrite,
   input armCorePkg::wordT instrAdr
);
   int assertFailures = 0;   // Number of failed assertions

   // No store may leave the core while it is held in reset
   memWriteLowInReset: assert property (@(posedge clk) reset |-> !memWrite)
      else begin
         $error("memWrite high during reset");
         assertFailures++;
      end

   instrAdrAligned: assert property (@(posedge clk) disable iff (reset)
                                     instrAdr[1:0] == 2'b00)
      else begin
         $error("instrAdr %h is not word aligned", instrAdr);
         assertFailures++;
      end

   outputsKnown: assert property (@(posedge clk) disable iff (reset)
                                  !$isunknown({memWrite, instrAdr}))
      else begin
         $error("memWrite or instrAdr unknown after reset");
         assertFailures++;
      end

endmodule

bind armCore armCore_checker protocolCheck (
   .clk      (clk),
   .reset    (reset),
   .memWrite (memWrite),
   .instrAdr (instrAdr)
);

// ==== verif/armCore_tb.sv ====
// Testbench for armCore with clock, reset, memory models, stimulus loading, store and PC checks
`timescale 1ns/1ps

module armCore_tb;

   localparam int    IMEM_WORDS   = 64;     // Indexed by address bits 7:2
   localparam int    DMEM_WORDS   = 64;
   localparam int    RESET_CYCLES = 4;
   localparam int    MAX_CYCLES   = 400;
   localparam int    HALT_CYCLES  = 2;      // Cycles spent at the halt address before passing
   localparam string STIM_FILE    = "verif/armStimulus.txt";

   logic             clk;
   logic             reset;
   armCorePkg::wordT instr;
   armCorePkg::wordT readData;
   armCorePkg::wordT instrAdr;
   logic             memWrite;
   armCorePkg::wordT dataAdr;
   armCorePkg::wordT writeData;

   armCorePkg::wordT imem [0:IMEM_WORDS-1];
   armCorePkg::wordT dmem [0:DMEM_WORDS-1];
   armCorePkg::wordT expAdr [$];             // Expected stores in program order
   armCorePkg::wordT expData [$];
   armCorePkg::wordT haltAdr;
   logic             haltFound;
   logic             done;
   int               cycle;
   int               haltCount;

   armCore dut (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .instrAdr  (instrAdr),
      .memWrite  (memWrite),
      .dataAdr   (dataAdr),
      .writeData (writeData)
   );

   always #4 clk = ~clk;

   // Both memories answer in the same cycle
   assign instr    = imem[instrAdr[7:2]];
   assign readData = dmem[dataAdr[7:2]];

   always @(posedge clk) begin
      if (memWrite) begin
         dmem[dataAdr[7:2]] <= writeData;   // Store commits at the edge
      end
   end

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic checkWord(input armCorePkg::wordT actual, input armCorePkg::wordT expected,
                            input string name);
      if (actual !== expected) begin
         abortRun($sformatf("FAIL time=%0t signal=%s expected=%h actual=%h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic checkAdr(input armCorePkg::wordT actual, input armCorePkg::wordT expected,
                           input string name);
      if (actual !== expected) begin
         abortRun($sformatf("FAIL time=%0t signal=%s expected address=%h actual address=%h",
                            $time, name, expected, actual));
      end
   endtask

   task automatic skipRestOfLine(input int fd);
      int c;
      c = $fgetc(fd);
      while (c != "\n" && c != -1) begin
         c = $fgetc(fd);
      end
   endtask

   task automatic checkStore();
      if (expAdr.size() == 0) begin
         abortRun($sformatf("Unexpected extra store of %h to address %h at time %0t",
                            writeData, dataAdr, $time));
      end else begin
         checkWord(dataAdr, expAdr.pop_front(), "dataAdr");
         checkWord(writeData, expData.pop_front(), "writeData");
      end
   endtask

   task automatic loadStimulus();
      int               fd;
      int               n;
      int               i;
      int               progAdr;
      logic [7:0]       tag;
      armCorePkg::wordT w [0:3];
      progAdr   = 0;
      haltFound = 1'b0;
      for (i = 0; i < IMEM_WORDS; i++) begin
         imem[i] = '0;
      end
      for (i = 0; i < DMEM_WORDS; i++) begin
         dmem[i] = '0;
      end
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         abortRun({"Cannot open the stimulus file ", STIM_FILE});
      end else begin
         while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", tag);
            if (n == 1) begin
               case (tag)
                  "P": begin
                     n = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
                     if (n != 4 || progAdr + 4 > IMEM_WORDS) begin
                        abortRun("Program line is malformed or overflows instruction memory");
                     end
                     for (i = 0; i < 4; i++) begin
                        imem[progAdr+i] = w[i];
                     end
                     progAdr += 4;
                  end
                  "S": begin
                     n = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
                     if (n != 4) begin
                        abortRun("Store line in the stimulus file is malformed");
                     end
                     expAdr.push_back(w[0]);
                     expData.push_back(w[1]);
                     expAdr.push_back(w[2]);
                     expData.push_back(w[3]);
                  end
                  "H": begin
                     n = $fscanf(fd, "%h", haltAdr);
                     haltFound = (n == 1);
                  end
                  "#": begin
                  end
                  default: abortRun("Unknown line tag in the stimulus file");
               endcase
               skipRestOfLine(fd);   // Drops comments after the values
            end
         end
         $fclose(fd);
      end
      if (!haltFound) begin
         abortRun("The stimulus file gives no halt address");
      end
   endtask

   initial begin
      clk       = 1'b0;
      reset     = 1'b1;
      done      = 1'b0;
      haltCount = 0;
      loadStimulus();
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
      // Mid-cycle sampling, outputs have settled since the last edge
      for (cycle = 0; cycle < MAX_CYCLES && !done; cycle++) begin
         @(negedge clk);
         if (dut.protocolCheck.assertFailures != 0) begin
            abortRun($sformatf("%0d assertion failures in the bound checker",
                               dut.protocolCheck.assertFailures));
         end
         if (memWrite) begin
            checkStore();
         end
         if (expAdr.size() == 0 && instrAdr == haltAdr) begin
            haltCount++;
         end else begin
            haltCount = 0;
         end
         done = (haltCount >= HALT_CYCLES);
      end
      if (done) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         // All stores seen, so the core should be spinning at the halt loop
         if (expAdr.size() == 0) begin
            checkAdr(instrAdr, haltAdr, "instrAdr");
         end
         abortRun($sformatf("Timeout after %0d cycles with %0d stores pending and PC at %h",
                            MAX_CYCLES, expAdr.size(), instrAdr));
      end
   end

endmodule

// ==== verif/armStimulus.txt ====
# P: four program words in address order. S: two expected stores as address and data pairs
# H: halt address. A # starts a comment, also after the values of a line
P E20F0000 E2801005 E280200C E0813002   # 00 clear R0, ADD imm and reg
P E2434014 E0425001 E203601C E1817002   # 10 SUB imm and reg, AND imm, ORR reg
P E38180F0 E0049002 E5803040 E5804044   # 20 ORR imm, AND reg, stores
P E5805048 E580604C E5807050 E5808054   # 30 stores
P E5809058 E590A044 E580A05C E051B001   # 40 LDR round trip, SUBS equal
P E281B001 05801060 15802060 95802064   # 50 ADD keeps flags, EQ NE LS
P 85801064 C5801068 D5801068 E051B002   # 60 HI GT LE, SUBS unequal
P 1580506C 35807070 25801070 B5806074   # 70 NE CC CS LT
P A5806074 E094B002 2580B078 7580807C   # 80 GE, ADDS carry, CS VC
P 6580807C E280C001 E280D01E E08CC00C   # 90 VS, doubling loop
P E25DD001 1AFFFFFC E09CB00C 6580C080   # A0 ADDS overflow, VS
P A580B080 E391B000 6580A084 4580A084   # B0 GE, ORRS keeps C and V, VS MI
P 35801088 EA000000 E580108C E280D003   # C0 CC, forward B skips a store
P E580D090 E25DD001 1AFFFFFC E580F094   # D0 store loop, STR R15
P EAFFFFFE 00000000 00000000 00000000   # E0 halt loop
S 00000040 00000011 00000044 FFFFFFFD
S 00000048 00000007 0000004C 00000010
S 00000050 0000000D 00000054 000000F5
S 00000058 0000000C 0000005C FFFFFFFD
S 00000060 00000005 00000064 0000000C
S 00000068 00000005 0000006C 00000007
S 00000070 0000000D 00000074 00000010
S 00000078 00000009 0000007C 000000F5
S 00000080 40000000 00000080 80000000
S 00000084 FFFFFFFD 00000088 00000005
S 00000090 00000003 00000090 00000002
S 00000090 00000001 00000094 000000E4
H 000000E0

// ==== build.f ====
logic/armCorePkg.sv
logic/armIsaPkg.sv
logic/armControl.sv
logic/pcUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/armCore.sv
verif/armCore_checker.sv
verif/armCore_tb.sv
